// File: bench/idu_checker.sv
`timescale 1ns/10ps
`default_nettype none

module idu_checker (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 check_en_i,
  input  wire logic                 quiet_i,
  input  wire logic                 done_i,
  input  wire logic [31:0]          rec_i,
  input  logic [31:0]               exp_i [14],
  input  wire logic [31:0]          inst_i,
  input  wire logic                 inst_ready_i,
  input  wire logic                 decode_valid_i,
  input  wire logic                 stall_i,
  input  wire idu_pkg::reg_idx_t    rd_idx_i,
  input  wire idu_pkg::imm_t        imm_i,
  input  wire idu_pkg::xlen_t       rs1_data_i,
  input  wire idu_pkg::xlen_t       rs2_data_i,
  input  wire idu_pkg::alu_op_t     alu_op_i,
  input  wire idu_pkg::exc_op_t     exc_op_i,
  input  wire idu_pkg::mem_op_t     mem_op_i,
  input  wire idu_pkg::csr_op_t     csr_op_i,
  input  wire idu_pkg::trap_t       trap_i,
  input  wire logic                 ras_push_valid_i,
  input  wire idu_pkg::xlen_t       ras_push_addr_i,
  input  wire idu_pkg::csr_idx_t    csr_idx_i,
  input  wire logic                 csr_uimm_valid_i,
  input  wire idu_pkg::reg_idx_t    rs1_idx_i,
  input  wire idu_pkg::reg_idx_t    rs2_idx_i,
  input  wire idu_pkg::imm_t        csr_uimm_i,
  output logic [31:0]               err_cnt_o,
  output logic [31:0]               chk_cnt_o
);
  import idu_pkg::*;

  int    err_cnt = 0;
  int    chk_cnt = 0;
  string fname [19] = '{"rd_idx", "imm", "rs1_data", "rs2_data", "alu_op", "exc_op",
                        "mem_op", "csr_op", "trap", "stall", "ras_push_valid",
                        "ras_push_addr", "csr_idx", "csr_uimm_valid", "decode_valid",
                        "inst_ready", "rs1_idx", "rs2_idx", "csr_uimm"};

  assign err_cnt_o = 32'(err_cnt);
  assign chk_cnt_o = 32'(chk_cnt);

  function automatic string exc_name(input exc_op_t op);
    case (op)
      EXC_LUI:    return "LUI";
      EXC_AUIPC:  return "AUIPC";
      EXC_JAL:    return "JAL";
      EXC_JALR:   return "JALR";
      EXC_LOAD:   return "LOAD";
      EXC_STORE:  return "STORE";
      EXC_BRANCH: return "BRANCH";
      EXC_OPIMM:  return "OPIMM";
      EXC_OPREG:  return "OPREG";
      EXC_CSR:    return "CSR";
      default:    return "EXC_NONE";
    endcase
  endfunction

  task automatic compare_outputs();
    logic [31:0] act [19];
    logic [31:0] exp [19];
    string       name;
    exc_op_t     exc;
    logic        uses_rs1;
    logic        uses_rs2;
    act = '{32'(rd_idx_i), imm_i, rs1_data_i, rs2_data_i, 32'(alu_op_i), 32'(exc_op_i),
            32'(mem_op_i), 32'(csr_op_i), 32'(trap_i), 32'(stall_i), 32'(ras_push_valid_i),
            ras_push_addr_i, 32'(csr_idx_i), 32'(csr_uimm_valid_i), 32'(decode_valid_i),
            32'(inst_ready_i), 32'(rs1_idx_i), 32'(rs2_idx_i), csr_uimm_i};
    for (int k = 0; k < 14; k++) begin
      exp[k] = exp_i[k];
    end
    // a stalled slot is neither valid nor ready
    exp[14] = {31'b0, !exp_i[9][0]};
    exp[15] = {31'b0, !exp_i[9][0]};
    // source fields by format, x0 where the format has none
    exc = exp_i[5][3:0];
    uses_rs1 = (exc inside {EXC_JALR, EXC_LOAD, EXC_STORE, EXC_BRANCH, EXC_OPIMM, EXC_OPREG})
               || (exc == EXC_CSR && !exp_i[13][0]);
    uses_rs2 = exc inside {EXC_STORE, EXC_BRANCH, EXC_OPREG};
    exp[16] = uses_rs1 ? {27'b0, inst_i[19:15]} : 32'b0;
    exp[17] = uses_rs2 ? {27'b0, inst_i[24:20]} : 32'b0;
    exp[18] = {27'b0, inst_i[19:15]};
    name = $sformatf("rec%0d_%s", rec_i, exc_name(exc));
    chk_cnt++;
    if (!(decode_valid_i || stall_i)) begin
      err_cnt++;
      $display("error: %s produced no decode output", name);
    end else begin
      for (int k = 0; k < 19; k++) begin
        // the csr immediate only means something for the immediate forms
        if ((k != 18 || exp_i[13][0]) && act[k] !== exp[k]) begin
          err_cnt++;
          $display("** Error %s %s: expected %h, actual %h", name, fname[k], exp[k], act[k]);
        end
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i && !done_i) begin
      if (check_en_i && !quiet_i) begin
        compare_outputs();
      end else if (decode_valid_i || stall_i || ras_push_valid_i || !inst_ready_i) begin
        // empty stage, incl. after a flush
        err_cnt++;
        $display("error: stage active with no instruction in it, near rec%0d", rec_i);
      end else if (check_en_i) begin
        chk_cnt++;
      end
    end
  end

  always @(posedge done_i) begin
    $display("checker: %0d checks, %0d errors", chk_cnt, err_cnt);
  end

endmodule

`default_nettype wire

// File: bench/idu_stim.txt
// ctrl addr inst trap_i rs1d rs2d exa exd exl mema memd (ctrl 1 flush, 2 resume, ff end)
// rd imm rs1o rs2o alu exc mem csr trap stall rasv rasa csr_idx uimm_v
0 100 002081b3 3c 11 22 0 e0 0 0 d0  3 0 11 22 1 9 0 0 0 0 0 104 0 0
0 104 407302b3 0 11 22 6 e0 0 6 d0  5 0 e0 22 2 9 0 0 0 0 0 108 0 0
0 108 02a48433 0 11 22 0 e0 0 a d0  8 0 11 d0 11 9 0 0 0 0 0 10c 0 0
0 10c 02d675b3 0 11 22 0 e0 0 0 d0  b 0 11 22 18 9 0 0 0 0 0 110 0 0
0 110 403150b3 0 11 22 0 e0 0 0 d0  1 0 11 22 8 9 0 0 0 0 0 114 0 0
0 114 002001b3 0 11 22 0 e0 1 0 d0  3 0 11 22 1 9 0 0 0 0 0 118 0 0
0 118 fff10093 40 11 22 0 e0 0 0 d0  1 ffffffff 11 22 1 8 0 0 40 0 0 11c 0 0
0 11c 4032d213 0 11 22 0 e0 0 0 d0  4 403 11 22 8 8 0 0 0 0 0 120 0 0
0 120 00808283 0 11 22 0 e0 0 0 d0  5 8 11 22 1 5 1 0 0 0 0 124 0 0
0 124 ffc09283 0 11 22 0 e0 0 0 d0  5 fffffffc 11 22 1 5 2 0 0 0 0 128 0 0
0 128 00012303 0 11 22 0 e0 0 0 d0  6 0 11 22 1 5 3 0 0 0 0 12c 0 0
0 12c 00114383 0 11 22 0 e0 0 0 d0  7 1 11 22 1 5 4 0 0 0 0 130 0 0
0 130 00215383 0 11 22 0 e0 0 0 d0  7 2 11 22 1 5 5 0 0 0 0 134 0 0
0 134 0020a623 0 11 22 0 e0 0 0 d0  0 c 11 22 1 6 8 0 0 0 0 138 0 0
0 138 fe320fa3 0 11 22 0 e0 0 0 d0  0 ffffffff 11 22 1 6 6 0 0 0 0 13c 0 0
0 13c 00208863 0 11 22 0 e0 0 0 d0  0 10 11 22 b 7 0 0 0 0 0 140 0 0
0 140 fe20fce3 0 11 22 0 e0 0 0 d0  0 fffffff8 11 22 10 7 0 0 0 0 0 144 0 0
0 144 12345537 0 11 22 0 e0 0 0 d0  a 12345000 11 22 1 1 0 0 0 0 0 148 0 0
0 148 fffff597 0 11 22 0 e0 0 0 d0  b fffff000 11 22 1 2 0 0 0 0 0 14c 0 0
0 14c 001000ef 0 11 22 0 e0 0 0 d0  1 800 11 22 1 3 0 0 0 0 1 150 0 0
0 150 0080006f 0 11 22 0 e0 0 0 d0  0 8 11 22 1 3 0 0 0 0 0 154 0 0
0 154 004082e7 0 11 22 0 e0 0 0 d0  5 4 11 22 1 4 0 0 0 0 1 158 0 0
0 158 00008067 0 11 22 0 e0 0 0 d0  0 0 11 22 1 4 0 0 0 0 0 15c 0 0
0 15c 300110f3 0 11 22 0 e0 0 0 d0  1 300 11 22 1 a 0 1 0 0 0 160 300 0
0 160 3052e1f3 0 11 22 0 e0 0 0 d0  3 305 11 22 1 a 0 2 0 0 0 164 305 1
0 164 34133273 0 11 22 0 e0 0 0 d0  4 341 11 22 1 a 0 3 0 0 0 168 341 0
0 168 00000073 0 11 22 0 e0 0 0 d0  0 0 11 22 0 0 0 0 10 0 0 16c 0 0
0 16c 00100073 0 11 22 0 e0 0 0 d0  0 0 11 22 0 0 0 0 8 0 0 170 0 0
0 170 30200073 0 11 22 0 e0 0 0 d0  0 0 11 22 0 0 0 0 20 0 0 174 0 0
0 174 00000000 83 11 22 0 e0 0 0 d0  0 0 11 22 0 0 0 0 87 0 0 178 0 0
0 178 002081b3 0 11 22 2 e0 1 0 d0  3 0 11 e0 1 9 0 0 0 1 0 17c 0 0
2 178 002081b3 0 11 22 2 e0 0 0 d0  3 0 11 e0 1 9 0 0 0 0 0 17c 0 0
1 17c 001000ef 0 11 22 0 e0 0 0 d0  0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 180 002081b3 0 11 22 0 e0 0 0 d0  3 0 11 22 1 9 0 0 0 0 0 184 0 0
ff

// File: bench/tb_idu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_idu;
  import idu_pkg::*;

  localparam int FIELDS     = 25;
  localparam int MAX_REC    = 64;
  localparam int CLK_PERIOD = 20;

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        inst_valid;
  xlen_t       inst_addr;
  inst_t       inst_data;
  trap_t       trap_in;
  xlen_t       rs1_data;
  xlen_t       rs2_data;
  reg_idx_t    ex_addr;
  xlen_t       ex_data;
  logic        ex_load;
  reg_idx_t    mem_addr;
  xlen_t       mem_data;

  logic        inst_ready;
  logic        decode_valid;
  logic        stall;
  reg_idx_t    rs1_idx;
  reg_idx_t    rs2_idx;
  reg_idx_t    rd_idx;
  xlen_t       rs1_fwd;
  xlen_t       rs2_fwd;
  imm_t        imm;
  csr_idx_t    csr_idx;
  imm_t        csr_uimm;
  logic        csr_uimm_valid;
  alu_op_t     alu_op;
  mem_op_t     mem_op;
  exc_op_t     exc_op;
  csr_op_t     csr_op;
  trap_t       trap_out;
  logic        ras_valid;
  xlen_t       ras_addr;

  // one record: ctrl, 10 inputs, 14 expected values
  logic [31:0] stim_mem [FIELDS*MAX_REC];
  logic [31:0] exp_w [14];
  logic [31:0] cur_rec;
  logic [31:0] err_cnt;
  logic [31:0] chk_cnt;
  logic        check_en;
  logic        quiet;
  logic        run_done;
  int          n_rec;

  always #(CLK_PERIOD/2) clk = ~clk;

  idu_stage idu_stage_inst (
    .clk_i(clk), .rst_n_i(rst_n), .flush_i(flush), .inst_valid_i(inst_valid),
    .inst_addr_i(inst_addr), .inst_data_i(inst_data), .trap_i(trap_in),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .ex_rd_addr_i(ex_addr), .ex_rd_data_i(ex_data), .ex_is_load_i(ex_load),
    .mem_rd_addr_i(mem_addr), .mem_rd_data_i(mem_data),
    .inst_ready_o(inst_ready), .decode_valid_o(decode_valid), .stall_o(stall),
    .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx), .rd_idx_o(rd_idx),
    .rs1_data_o(rs1_fwd), .rs2_data_o(rs2_fwd), .imm_o(imm),
    .csr_idx_o(csr_idx), .csr_uimm_o(csr_uimm), .csr_uimm_valid_o(csr_uimm_valid),
    .alu_op_o(alu_op), .mem_op_o(mem_op), .exc_op_o(exc_op), .csr_op_o(csr_op),
    .trap_o(trap_out), .ras_push_valid_o(ras_valid), .ras_push_addr_o(ras_addr)
  );

  idu_checker idu_checker_inst (
    .clk_i(clk), .rst_n_i(rst_n), .check_en_i(check_en), .quiet_i(quiet),
    .done_i(run_done), .rec_i(cur_rec), .exp_i(exp_w), .inst_i(inst_data),
    .inst_ready_i(inst_ready), .decode_valid_i(decode_valid), .stall_i(stall),
    .rd_idx_i(rd_idx), .imm_i(imm), .rs1_data_i(rs1_fwd), .rs2_data_i(rs2_fwd),
    .alu_op_i(alu_op), .exc_op_i(exc_op), .mem_op_i(mem_op), .csr_op_i(csr_op),
    .trap_i(trap_out), .ras_push_valid_i(ras_valid), .ras_push_addr_i(ras_addr),
    .csr_idx_i(csr_idx), .csr_uimm_valid_i(csr_uimm_valid),
    .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx), .csr_uimm_i(csr_uimm),
    .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
  );

  // hold the instruction until a rising edge sees ready
  task automatic wait_accept();
    logic accepted;
    do begin
      @(negedge clk);
      accepted = inst_ready;
      @(posedge clk);
    end while (!accepted);
  endtask

  task automatic drive_record(input int r);
    int b;
    b = r * FIELDS;
    check_en   = 1'b0;
    flush      = stim_mem[b][0];
    inst_addr  = stim_mem[b+1];
    inst_data  = stim_mem[b+2];
    trap_in    = stim_mem[b+3][7:0];
    rs1_data   = stim_mem[b+4];
    rs2_data   = stim_mem[b+5];
    ex_addr    = stim_mem[b+6][4:0];
    ex_data    = stim_mem[b+7];
    ex_load    = stim_mem[b+8][0];
    mem_addr   = stim_mem[b+9][4:0];
    mem_data   = stim_mem[b+10];
    // resume records only release a stalled instruction
    if (!stim_mem[b][1]) begin
      inst_valid = 1'b1;
      wait_accept();
      #1;
      inst_valid = 1'b0;
      flush      = 1'b0;
    end
    for (int k = 0; k < 14; k++) begin
      exp_w[k] = stim_mem[b+11+k];
    end
    quiet    = stim_mem[b][0];
    cur_rec  = 32'(r);
    check_en = 1'b1;
    @(posedge clk);
    #1;
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    flush = 1'b0;
    inst_valid = 1'b0;
    inst_addr = '0;
    inst_data = '0;
    trap_in = '0;
    rs1_data = '0;
    rs2_data = '0;
    ex_addr = '0;
    ex_data = '0;
    ex_load = 1'b0;
    mem_addr = '0;
    mem_data = '0;
    check_en = 1'b0;
    quiet = 1'b0;
    run_done = 1'b0;
    cur_rec = '0;
    for (int k = 0; k < 14; k++) begin
      exp_w[k] = '0;
    end
    for (int a = 0; a < FIELDS*MAX_REC; a++) begin
      stim_mem[a] = 32'h5a5a_0000 ^ 32'(a);
    end
    $readmemh("bench/idu_stim.txt", stim_mem);
    n_rec = 0;
    while (n_rec < MAX_REC && stim_mem[n_rec*FIELDS] != 32'hff) begin
      n_rec++;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int r = 0; r < n_rec; r++) begin
      drive_record(r);
    end
    check_en = 1'b0;
    repeat (2) @(posedge clk);
    run_done = 1'b1;
    #1;
    if (err_cnt == 0 && chk_cnt > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog sized from the stimulus length
  initial begin
    #1;
    repeat (n_rec*10 + 100) @(posedge clk);
    $display("watchdog: run timed out after %0d cycles", n_rec*10 + 100);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_idu -f sources.f -o tb_idu_sim

./obj_dir/tb_idu_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// File: sources.f
src/idu_pkg.sv
src/idu_fetch_latch.sv
src/idu_decoder.sv
src/idu_operand_fwd.sv
src/idu_stage.sv
bench/idu_checker.sv
bench/tb_idu.sv

// File: src/idu_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module idu_decoder (
  input  wire logic              id_valid_i,
  input  wire idu_pkg::xlen_t    id_addr_i,
  input  wire idu_pkg::inst_t    id_inst_i,
  input  wire idu_pkg::trap_t    id_trap_i,
  output idu_pkg::reg_idx_t      rs1_idx_o,
  output idu_pkg::reg_idx_t      rs2_idx_o,
  output idu_pkg::reg_idx_t      rd_idx_o,
  output idu_pkg::imm_t          imm_o,
  output idu_pkg::csr_idx_t      csr_idx_o,
  output idu_pkg::imm_t          csr_uimm_o,
  output logic                   csr_uimm_valid_o,
  output idu_pkg::alu_op_t       alu_op_o,
  output idu_pkg::mem_op_t       mem_op_o,
  output idu_pkg::exc_op_t       exc_op_o,
  output idu_pkg::csr_op_t       csr_op_o,
  output idu_pkg::trap_t         trap_o,
  output logic                   ras_push_valid_o,
  output idu_pkg::xlen_t         ras_push_addr_o
);
  import idu_pkg::*;

  wire logic [2:0] f3 = id_inst_i[14:12];

  wire logic op_branch = inst_match(id_inst_i, MASK_OPCODE, OPC_BRANCH);
  wire logic op_load   = inst_match(id_inst_i, MASK_OPCODE, OPC_LOAD);
  wire logic op_store  = inst_match(id_inst_i, MASK_OPCODE, OPC_STORE);
  wire logic op_opimm  = inst_match(id_inst_i, MASK_OPCODE, OPC_OPIMM);
  wire logic op_system = inst_match(id_inst_i, MASK_OPCODE, OPC_SYSTEM);

  // func7 variants of op-imm shifts and register ops
  wire logic imm_f7_base = inst_match(id_inst_i, MASK_FUNC7, OPC_OPIMM);
  wire logic imm_f7_alt  = inst_match(id_inst_i, MASK_FUNC7, OPC_OPIMM | FUNC7_ALT);
  wire logic reg_f7_base = inst_match(id_inst_i, MASK_FUNC7, OPC_OP);
  wire logic reg_f7_alt  = inst_match(id_inst_i, MASK_FUNC7, OPC_OP | FUNC7_ALT);
  wire logic reg_f7_mul  = inst_match(id_inst_i, MASK_FUNC7, OPC_OP | FUNC7_MULDIV);

  wire logic shift_ok = (f3 == 3'b001 && imm_f7_base) ||
                        (f3 == 3'b101 && (imm_f7_base || imm_f7_alt));

  // execute classes
  wire logic cls_lui    = inst_match(id_inst_i, MASK_OPCODE, OPC_LUI);
  wire logic cls_auipc  = inst_match(id_inst_i, MASK_OPCODE, OPC_AUIPC);
  wire logic cls_jal    = inst_match(id_inst_i, MASK_OPCODE, OPC_JAL);
  wire logic cls_jalr   = inst_match(id_inst_i, MASK_FUNC3, OPC_JALR);
  wire logic cls_branch = op_branch && (f3[2:1] != 2'b01);
  wire logic cls_load   = op_load && (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
  wire logic cls_store  = op_store && (f3 inside {3'b000, 3'b001, 3'b010});
  wire logic cls_opimm  = op_opimm && ((f3[1:0] != 2'b01) || shift_ok);
  wire logic cls_opreg  = reg_f7_base || reg_f7_mul ||
                          (reg_f7_alt && (f3 == 3'b000 || f3 == 3'b101));
  wire logic cls_csr    = op_system && (f3[1:0] != 2'b00);

  wire logic is_ecall  = inst_match(id_inst_i, MASK_ALL, ECALL_WORD);
  wire logic is_ebreak = inst_match(id_inst_i, MASK_ALL, EBREAK_WORD);
  wire logic is_mret   = inst_match(id_inst_i, MASK_ALL, MRET_WORD);

  wire logic [9:0] cls_vec = {cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch,
                              cls_load, cls_store, cls_opimm, cls_opreg, cls_csr};
  wire logic legal = (|cls_vec) || is_ecall || is_ebreak || is_mret;

  // csrr*i carries uimm where rs1 would be
  wire logic need_rs1 = cls_jalr || cls_branch || cls_load || cls_store ||
                        cls_opimm || cls_opreg || (cls_csr && !f3[2]);
  wire logic need_rs2 = cls_branch || cls_store || cls_opreg;
  wire logic need_rd  = cls_lui || cls_auipc || cls_jal || cls_jalr ||
                        cls_load || cls_opimm || cls_opreg || cls_csr;

  wire imm_t imm_i = {{20{id_inst_i[31]}}, id_inst_i[31:20]};
  wire imm_t imm_s = {{20{id_inst_i[31]}}, id_inst_i[31:25], id_inst_i[11:7]};
  wire imm_t imm_b = {{19{id_inst_i[31]}}, id_inst_i[31], id_inst_i[7],
                      id_inst_i[30:25], id_inst_i[11:8], 1'b0};
  wire imm_t imm_u = {id_inst_i[31:12], 12'b0};
  wire imm_t imm_j = {{11{id_inst_i[31]}}, id_inst_i[31], id_inst_i[19:12],
                      id_inst_i[20], id_inst_i[30:21], 1'b0};

  assign rs1_idx_o = need_rs1 ? id_inst_i[19:15] : '0;
  assign rs2_idx_o = need_rs2 ? id_inst_i[24:20] : '0;
  assign rd_idx_o  = need_rd ? id_inst_i[11:7] : '0;
  assign csr_idx_o = cls_csr ? id_inst_i[31:20] : '0;
  assign csr_uimm_o       = {27'b0, id_inst_i[19:15]};
  assign csr_uimm_valid_o = cls_csr && f3[2];

  always_comb begin
    if (cls_jalr || cls_load || cls_opimm || cls_csr) begin
      imm_o = imm_i;
    end else if (cls_store) begin
      imm_o = imm_s;
    end else if (cls_branch) begin
      imm_o = imm_b;
    end else if (cls_lui || cls_auipc) begin
      imm_o = imm_u;
    end else if (cls_jal) begin
      imm_o = imm_j;
    end else begin
      imm_o = '0;
    end
  end

  always_comb begin
    alu_op_o = ALU_NONE;
    mem_op_o = MEM_NONE;
    exc_op_o = EXC_NONE;
    csr_op_o = CSR_NONE;
    // address and link arithmetic all run through the adder
    if (cls_lui || cls_auipc || cls_jal || cls_jalr || cls_load || cls_store || cls_csr) begin
      alu_op_o = ALU_ADD;
    end
    if (cls_lui) exc_op_o = EXC_LUI;
    if (cls_auipc) exc_op_o = EXC_AUIPC;
    if (cls_jal) exc_op_o = EXC_JAL;
    if (cls_jalr) exc_op_o = EXC_JALR;
    if (cls_load) begin
      exc_op_o = EXC_LOAD;
      case (f3)
        3'b000:  mem_op_o = MEM_LB;
        3'b001:  mem_op_o = MEM_LH;
        3'b010:  mem_op_o = MEM_LW;
        3'b100:  mem_op_o = MEM_LBU;
        default: mem_op_o = MEM_LHU;
      endcase
    end
    if (cls_store) begin
      exc_op_o = EXC_STORE;
      case (f3)
        3'b000:  mem_op_o = MEM_SB;
        3'b001:  mem_op_o = MEM_SH;
        default: mem_op_o = MEM_SW;
      endcase
    end
    if (cls_branch) begin
      exc_op_o = EXC_BRANCH;
      case (f3)
        3'b000:  alu_op_o = ALU_BEQ;
        3'b001:  alu_op_o = ALU_BNE;
        3'b100:  alu_op_o = ALU_BLT;
        3'b101:  alu_op_o = ALU_BGE;
        3'b110:  alu_op_o = ALU_BLTU;
        default: alu_op_o = ALU_BGEU;
      endcase
    end
    if (cls_opreg && reg_f7_mul) begin
      exc_op_o = EXC_OPREG;
      case (f3)
        3'b000:  alu_op_o = ALU_MUL;
        3'b001:  alu_op_o = ALU_MULH;
        3'b010:  alu_op_o = ALU_MULHSU;
        3'b011:  alu_op_o = ALU_MULHU;
        3'b100:  alu_op_o = ALU_DIV;
        3'b101:  alu_op_o = ALU_DIVU;
        3'b110:  alu_op_o = ALU_REM;
        default: alu_op_o = ALU_REMU;
      endcase
    end else if (cls_opreg || cls_opimm) begin
      exc_op_o = cls_opimm ? EXC_OPIMM : EXC_OPREG;
      case (f3)
        3'b000:  alu_op_o = reg_f7_alt ? ALU_SUB : ALU_ADD;
        3'b001:  alu_op_o = ALU_SLL;
        3'b010:  alu_op_o = ALU_SLT;
        3'b011:  alu_op_o = ALU_SLTU;
        3'b100:  alu_op_o = ALU_XOR;
        3'b101:  alu_op_o = (reg_f7_alt || imm_f7_alt) ? ALU_SRA : ALU_SRL;
        3'b110:  alu_op_o = ALU_OR;
        default: alu_op_o = ALU_AND;
      endcase
    end
    if (cls_csr) begin
      exc_op_o = EXC_CSR;
      case (f3[1:0])
        2'b01:   csr_op_o = CSR_WRITE;
        2'b10:   csr_op_o = CSR_SET;
        default: csr_op_o = CSR_CLEAR;
      endcase
    end
  end

  // decode traps replace their bits, fetch traps ride along
  always_comb begin
    trap_o = id_trap_i;
    trap_o[TRAP_ILLEGAL] = !legal;
    trap_o[TRAP_ECALL]   = is_ecall;
    trap_o[TRAP_EBREAK]  = is_ebreak;
    trap_o[TRAP_MRET]    = is_mret;
  end

  // a link to a nonzero rd is a call
  assign ras_push_valid_o = id_valid_i && (cls_jal || cls_jalr) && (id_inst_i[11:7] != '0);
  assign ras_push_addr_o  = id_addr_i + RET_ADDR_STEP;

  always_comb begin
    assert final (!id_valid_i || $onehot0(cls_vec))
      else $error("more than one execute class matched %h", id_inst_i);
  end

endmodule

`default_nettype wire

// File: src/idu_fetch_latch.sv
`timescale 1ns/10ps
`default_nettype none

module idu_fetch_latch (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  input  wire logic           flush_i,
  input  wire logic           stall_i,
  input  wire logic           inst_valid_i,
  input  wire idu_pkg::xlen_t inst_addr_i,
  input  wire idu_pkg::inst_t inst_data_i,
  input  wire idu_pkg::trap_t trap_i,
  output logic                id_valid_o,
  output idu_pkg::xlen_t      id_addr_o,
  output idu_pkg::inst_t      id_inst_o,
  output idu_pkg::trap_t      id_trap_o
);

  // flush beats both a held and an incoming instruction
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      id_valid_o <= 1'b0;
    end else if (!stall_i) begin
      id_valid_o <= inst_valid_i;
    end
  end

  // payload moves only on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (!stall_i && inst_valid_i) begin
      id_addr_o <= inst_addr_i;
      id_inst_o <= inst_data_i;
      id_trap_o <= trap_i;
    end
  end

  // a stall only holds a live instruction, which stays valid and unchanged
  hold_on_stall: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    stall_i && !flush_i |=> id_valid_o && $stable(id_addr_o) && $stable(id_inst_o) &&
                            $stable(id_trap_o)
  ) else $error("if/id register emptied or loaded while stalled");

endmodule

`default_nettype wire

// File: src/idu_operand_fwd.sv
`timescale 1ns/10ps
`default_nettype none

module idu_operand_fwd (
  input  wire logic              id_valid_i,
  input  wire idu_pkg::reg_idx_t rs1_idx_i,
  input  wire idu_pkg::reg_idx_t rs2_idx_i,
  input  wire idu_pkg::xlen_t    rs1_data_i,
  input  wire idu_pkg::xlen_t    rs2_data_i,
  input  wire idu_pkg::xlen_t    ex_rd_data_i,
  input  wire idu_pkg::xlen_t    mem_rd_data_i,
  input  wire idu_pkg::reg_idx_t ex_rd_addr_i,
  input  wire idu_pkg::reg_idx_t mem_rd_addr_i,
  input  wire logic              ex_is_load_i,
  output idu_pkg::xlen_t         rs1_data_o,
  output idu_pkg::xlen_t         rs2_data_o,
  output logic                   stall_o,
  output logic                   decode_valid_o
);
  import idu_pkg::*;

  // x0 never forwards
  function automatic logic idx_hit(input reg_idx_t src, input reg_idx_t dst);
    return (src != '0) && (src == dst);
  endfunction

  wire logic rs1_ex_hit  = idx_hit(rs1_idx_i, ex_rd_addr_i);
  wire logic rs2_ex_hit  = idx_hit(rs2_idx_i, ex_rd_addr_i);
  wire logic rs1_mem_hit = idx_hit(rs1_idx_i, mem_rd_addr_i);
  wire logic rs2_mem_hit = idx_hit(rs2_idx_i, mem_rd_addr_i);

  // youngest producer first: execute, then memory, then the register file
  assign rs1_data_o = rs1_ex_hit ? ex_rd_data_i : (rs1_mem_hit ? mem_rd_data_i : rs1_data_i);
  assign rs2_data_o = rs2_ex_hit ? ex_rd_data_i : (rs2_mem_hit ? mem_rd_data_i : rs2_data_i);

  // load data is not ready in execute yet
  assign stall_o        = ex_is_load_i && id_valid_i && (rs1_ex_hit || rs2_ex_hit);
  assign decode_valid_o = id_valid_i && !stall_o;

endmodule

`default_nettype wire

// File: src/idu_pkg.sv
`default_nettype none

package idu_pkg;

  // field widths
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int CSR_IDX_W = 12;
  localparam int TRAP_W    = 8;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [31:0]          inst_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [CSR_IDX_W-1:0] csr_idx_t;
  typedef logic [XLEN-1:0]      imm_t;
  typedef logic [4:0]           alu_op_t;
  typedef logic [3:0]           mem_op_t;
  typedef logic [3:0]           exc_op_t;
  typedef logic [2:0]           csr_op_t;
  typedef logic [TRAP_W-1:0]    trap_t;

  // decode trap bits, the rest come from fetch
  localparam int TRAP_ILLEGAL = 2;
  localparam int TRAP_EBREAK  = 3;
  localparam int TRAP_ECALL   = 4;
  localparam int TRAP_MRET    = 5;

  // alu codes
  localparam alu_op_t ALU_NONE   = 5'd0;
  localparam alu_op_t ALU_ADD    = 5'd1;
  localparam alu_op_t ALU_SUB    = 5'd2;
  localparam alu_op_t ALU_XOR    = 5'd3;
  localparam alu_op_t ALU_OR     = 5'd4;
  localparam alu_op_t ALU_AND    = 5'd5;
  localparam alu_op_t ALU_SLL    = 5'd6;
  localparam alu_op_t ALU_SRL    = 5'd7;
  localparam alu_op_t ALU_SRA    = 5'd8;
  localparam alu_op_t ALU_SLT    = 5'd9;
  localparam alu_op_t ALU_SLTU   = 5'd10;
  localparam alu_op_t ALU_BEQ    = 5'd11;
  localparam alu_op_t ALU_BNE    = 5'd12;
  localparam alu_op_t ALU_BLT    = 5'd13;
  localparam alu_op_t ALU_BGE    = 5'd14;
  localparam alu_op_t ALU_BLTU   = 5'd15;
  localparam alu_op_t ALU_BGEU   = 5'd16;
  localparam alu_op_t ALU_MUL    = 5'd17;
  localparam alu_op_t ALU_MULH   = 5'd18;
  localparam alu_op_t ALU_MULHSU = 5'd19;
  localparam alu_op_t ALU_MULHU  = 5'd20;
  localparam alu_op_t ALU_DIV    = 5'd21;
  localparam alu_op_t ALU_DIVU   = 5'd22;
  localparam alu_op_t ALU_REM    = 5'd23;
  localparam alu_op_t ALU_REMU   = 5'd24;

  localparam mem_op_t MEM_NONE = 4'd0;
  localparam mem_op_t MEM_LB   = 4'd1;
  localparam mem_op_t MEM_LH   = 4'd2;
  localparam mem_op_t MEM_LW   = 4'd3;
  localparam mem_op_t MEM_LBU  = 4'd4;
  localparam mem_op_t MEM_LHU  = 4'd5;
  localparam mem_op_t MEM_SB   = 4'd6;
  localparam mem_op_t MEM_SH   = 4'd7;
  localparam mem_op_t MEM_SW   = 4'd8;

  localparam exc_op_t EXC_NONE   = 4'd0;
  localparam exc_op_t EXC_LUI    = 4'd1;
  localparam exc_op_t EXC_AUIPC  = 4'd2;
  localparam exc_op_t EXC_JAL    = 4'd3;
  localparam exc_op_t EXC_JALR   = 4'd4;
  localparam exc_op_t EXC_LOAD   = 4'd5;
  localparam exc_op_t EXC_STORE  = 4'd6;
  localparam exc_op_t EXC_BRANCH = 4'd7;
  localparam exc_op_t EXC_OPIMM  = 4'd8;
  localparam exc_op_t EXC_OPREG  = 4'd9;
  localparam exc_op_t EXC_CSR    = 4'd10;

  localparam csr_op_t CSR_NONE  = 3'd0;
  localparam csr_op_t CSR_WRITE = 3'd1;
  localparam csr_op_t CSR_SET   = 3'd2;
  localparam csr_op_t CSR_CLEAR = 3'd3;

  // match masks
  localparam inst_t MASK_OPCODE = 32'h0000_007f;
  localparam inst_t MASK_FUNC3  = 32'h0000_707f;
  localparam inst_t MASK_FUNC7  = 32'hfe00_007f;
  localparam inst_t MASK_ALL    = 32'hffff_ffff;

  // major opcodes, func3 and func7 zero
  localparam inst_t OPC_LUI    = 32'h0000_0037;
  localparam inst_t OPC_AUIPC  = 32'h0000_0017;
  localparam inst_t OPC_JAL    = 32'h0000_006f;
  localparam inst_t OPC_JALR   = 32'h0000_0067;
  localparam inst_t OPC_BRANCH = 32'h0000_0063;
  localparam inst_t OPC_LOAD   = 32'h0000_0003;
  localparam inst_t OPC_STORE  = 32'h0000_0023;
  localparam inst_t OPC_OPIMM  = 32'h0000_0013;
  localparam inst_t OPC_OP     = 32'h0000_0033;
  localparam inst_t OPC_SYSTEM = 32'h0000_0073;

  // func7 variants: sub/sra and the m extension
  localparam inst_t FUNC7_ALT    = 32'h4000_0000;
  localparam inst_t FUNC7_MULDIV = 32'h0200_0000;

  localparam inst_t ECALL_WORD  = 32'h0000_0073;
  localparam inst_t EBREAK_WORD = 32'h0010_0073;
  localparam inst_t MRET_WORD   = 32'h3020_0073;

  localparam xlen_t RET_ADDR_STEP = 32'd4;

  function automatic logic inst_match(input inst_t inst, input inst_t mask, input inst_t value);
    return (inst & mask) == value;
  endfunction

endpackage

`default_nettype wire

// File: src/idu_stage.sv
`timescale 1ns/10ps
`default_nettype none

module idu_stage (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              flush_i,
  input  wire logic              inst_valid_i,
  input  wire idu_pkg::xlen_t    inst_addr_i,
  input  wire idu_pkg::inst_t    inst_data_i,
  input  wire idu_pkg::trap_t    trap_i,
  input  wire idu_pkg::xlen_t    rs1_data_i,
  input  wire idu_pkg::xlen_t    rs2_data_i,
  input  wire idu_pkg::reg_idx_t ex_rd_addr_i,
  input  wire idu_pkg::xlen_t    ex_rd_data_i,
  input  wire logic              ex_is_load_i,
  input  wire idu_pkg::reg_idx_t mem_rd_addr_i,
  input  wire idu_pkg::xlen_t    mem_rd_data_i,
  output logic                   inst_ready_o,
  output logic                   decode_valid_o,
  output logic                   stall_o,
  output idu_pkg::reg_idx_t      rs1_idx_o,
  output idu_pkg::reg_idx_t      rs2_idx_o,
  output idu_pkg::reg_idx_t      rd_idx_o,
  output idu_pkg::xlen_t         rs1_data_o,
  output idu_pkg::xlen_t         rs2_data_o,
  output idu_pkg::imm_t          imm_o,
  output idu_pkg::csr_idx_t      csr_idx_o,
  output idu_pkg::imm_t          csr_uimm_o,
  output logic                   csr_uimm_valid_o,
  output idu_pkg::alu_op_t       alu_op_o,
  output idu_pkg::mem_op_t       mem_op_o,
  output idu_pkg::exc_op_t       exc_op_o,
  output idu_pkg::csr_op_t       csr_op_o,
  output idu_pkg::trap_t         trap_o,
  output logic                   ras_push_valid_o,
  output idu_pkg::xlen_t         ras_push_addr_o
);
  import idu_pkg::*;

  // if/id register contents
  logic  id_valid;
  xlen_t id_addr;
  inst_t id_inst;
  trap_t id_trap;

  // fetch stalls together with the latch
  assign inst_ready_o = !stall_o;

  idu_fetch_latch idu_fetch_latch_inst (
    .stall_i    (stall_o),
    .id_valid_o (id_valid),
    .id_addr_o  (id_addr),
    .id_inst_o  (id_inst),
    .id_trap_o  (id_trap),
    .*
  );

  idu_decoder idu_decoder_inst (
    .id_valid_i (id_valid),
    .id_addr_i  (id_addr),
    .id_inst_i  (id_inst),
    .id_trap_i  (id_trap),
    .*
  );

  idu_operand_fwd idu_operand_fwd_inst (
    .id_valid_i (id_valid),
    .rs1_idx_i  (rs1_idx_o),
    .rs2_idx_i  (rs2_idx_o),
    .*
  );

endmodule

`default_nettype wire
